//--- sim.f
logic/vbe_pkg.sv
logic/vbe_cmd_queue.sv
logic/vbe_dispatch.sv
logic/vbe_vrf.sv
logic/vbe_alu.sv
logic/vbe_mul.sv
logic/vbe_wb_arbiter.sv
logic/vbe_backend.sv
tests/tb_vbe_backend.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the vector backend testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --top-module tb_vbe_backend -f sim.f -o tb_vbe_backend
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/tb_vbe_backend > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
  exit 1
fi
exit 0

//--- tests/tb_vbe_backend.sv
`timescale 1ns/10ps

module tb_vbe_backend import vbe_pkg::*; ();

  localparam int NUM_ROWS       = 16;
  localparam int CQ_DEPTH       = 4;
  localparam int MUL_STAGES     = 3;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 40 + 200;

  logic             clk;
  logic             rst_n;
  logic             inst_valid_i;
  vbe_op_e          inst_op_i;
  logic [REG_W-1:0] inst_vd_i;
  logic [REG_W-1:0] inst_vs1_i;
  logic [REG_W-1:0] inst_vs2_i;
  logic [ELEN-1:0]  inst_imm_i;
  logic [TAG_W-1:0] inst_tag_i;
  logic             inst_ready_o;
  logic             rt_valid_o;
  logic [TAG_W-1:0] rt_tag_o;
  logic [REG_W-1:0] rt_vd_o;
  logic [VLEN-1:0]  rt_data_o;
  logic             rt_sat_o;
  logic             rt_ready_i;
  logic             vxsat_o;

  // Stimulus table with the tag equal to the row index
  vbe_op_e          row_op  [NUM_ROWS];
  logic [REG_W-1:0] row_vd  [NUM_ROWS];
  logic [REG_W-1:0] row_vs1 [NUM_ROWS];
  logic [REG_W-1:0] row_vs2 [NUM_ROWS];
  logic [ELEN-1:0]  row_imm [NUM_ROWS];
  logic [TAG_W-1:0] row_tag [NUM_ROWS];

  // Expected retire record per tag
  vbe_op_e          exp_op   [NUM_ROWS];
  logic [REG_W-1:0] exp_vd   [NUM_ROWS];
  logic [VLEN-1:0]  exp_data [NUM_ROWS];
  logic             exp_sat  [NUM_ROWS];
  logic             seen     [NUM_ROWS];

  logic monitor_on;
  logic sat_seen;
  logic ready_dropped;
  int   retired;
  int   mon_pass;
  int   mon_fail;
  int   main_pass;
  int   main_fail;

  vbe_backend #(
    .CQ_DEPTH  (CQ_DEPTH),
    .MUL_STAGES(MUL_STAGES)
  ) vbe_backend_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .inst_valid_i(inst_valid_i),
    .inst_op_i   (inst_op_i),
    .inst_vd_i   (inst_vd_i),
    .inst_vs1_i  (inst_vs1_i),
    .inst_vs2_i  (inst_vs2_i),
    .inst_imm_i  (inst_imm_i),
    .inst_tag_i  (inst_tag_i),
    .inst_ready_o(inst_ready_o),
    .rt_valid_o  (rt_valid_o),
    .rt_tag_o    (rt_tag_o),
    .rt_vd_o     (rt_vd_o),
    .rt_data_o   (rt_data_o),
    .rt_sat_o    (rt_sat_o),
    .rt_ready_i  (rt_ready_i),
    .vxsat_o     (vxsat_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [15:0] next_lfsr(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  // Lane arithmetic straight from the opcode definitions
  function automatic logic [VLEN-1:0] model_op(input vbe_op_e op, input logic [VLEN-1:0] a,
                                               input logic [VLEN-1:0] b,
                                               input logic [ELEN-1:0] imm, output logic sat);
    logic [ELEN-1:0] x;
    logic [ELEN-1:0] y;
    logic [ELEN-1:0] r;
    logic [ELEN:0]   s;
    logic [15:0]     p;
    logic [VLEN-1:0] res;
    sat = 1'b0;
    res = '0;
    for (int k = 0; k < NUM_LANES; k++) begin
      x = a[k*ELEN +: ELEN];
      y = b[k*ELEN +: ELEN];
      case (op)
        OP_LI:  r = imm;
        OP_ADD: r = x + y;
        OP_SUB: r = x - y;
        OP_SADDU: begin
          s = {1'b0, x} + {1'b0, y};
          r = s[ELEN] ? 8'hFF : s[ELEN-1:0];
          if (s[ELEN]) sat = 1'b1;
        end
        OP_AND: r = x & y;
        OP_XOR: r = x ^ y;
        default: begin
          p = 16'(x) * 16'(y);
          r = p[7:0];
        end
      endcase
      res[k*ELEN +: ELEN] = r;
    end
    return res;
  endfunction

  task automatic set_row(input int idx, input vbe_op_e op, input logic [REG_W-1:0] vd,
                         input logic [REG_W-1:0] vs1, input logic [REG_W-1:0] vs2,
                         input logic [ELEN-1:0] imm);
    row_op[idx]  = op;
    row_vd[idx]  = vd;
    row_vs1[idx] = vs1;
    row_vs2[idx] = vs2;
    row_imm[idx] = imm;
    row_tag[idx] = TAG_W'(idx);
  endtask

  task automatic load_table();
    set_row(0, OP_LI, 3'd1, 3'd0, 3'd0, 8'h13);
    set_row(1, OP_LI, 3'd2, 3'd0, 3'd0, 8'hF0);
    set_row(2, OP_AND, 3'd3, 3'd1, 3'd2, 8'h00);
    set_row(3, OP_XOR, 3'd4, 3'd1, 3'd2, 8'h00);
    // Wraps past 255
    set_row(4, OP_ADD, 3'd5, 3'd2, 3'd2, 8'h00);
    set_row(5, OP_SUB, 3'd6, 3'd1, 3'd2, 8'h00);
    set_row(6, OP_SADDU, 3'd7, 3'd1, 3'd1, 8'h00);
    // Overflows every lane
    set_row(7, OP_SADDU, 3'd0, 3'd2, 3'd1, 8'h00);
    set_row(8, OP_MUL, 3'd3, 3'd1, 3'd4, 8'h00);
    set_row(9, OP_MUL, 3'd5, 3'd4, 3'd4, 8'h00);
    set_row(10, OP_MUL, 3'd6, 3'd1, 3'd2, 8'h00);
    // Chain on a multiplier result
    set_row(11, OP_MUL, 3'd7, 3'd3, 3'd3, 8'h00);
    set_row(12, OP_ADD, 3'd1, 3'd3, 3'd5, 8'h00);
    set_row(13, OP_LI, 3'd2, 3'd0, 3'd0, 8'h7F);
    set_row(14, OP_SADDU, 3'd4, 3'd2, 3'd2, 8'h00);
    set_row(15, OP_XOR, 3'd0, 3'd6, 3'd7, 8'h00);
  endtask

  // Program order model since dispatch keeps dependencies intact
  task automatic build_expected();
    logic [VLEN-1:0] model_regs [NUM_VREG];
    logic [VLEN-1:0] res;
    logic            sat;
    for (int r = 0; r < NUM_VREG; r++) begin
      model_regs[r] = '0;
    end
    for (int i = 0; i < NUM_ROWS; i++) begin
      res = model_op(row_op[i], model_regs[row_vs1[i]], model_regs[row_vs2[i]],
                     row_imm[i], sat);
      model_regs[row_vd[i]] = res;
      exp_op[row_tag[i]]   = row_op[i];
      exp_vd[row_tag[i]]   = row_vd[i];
      exp_data[row_tag[i]] = res;
      exp_sat[row_tag[i]]  = sat;
    end
  endtask

  // Random retire stalls, hold check and compare by tag
  initial begin : retire_monitor
    logic [15:0]      lfsr;
    logic             hold_pending;
    logic [TAG_W-1:0] held_tag;
    logic [REG_W-1:0] held_vd;
    logic [VLEN-1:0]  held_data;
    logic             held_sat;
    lfsr         = 16'd74;
    rt_ready_i   = 1'b1;
    hold_pending = 1'b0;
    sat_seen     = 1'b0;
    retired      = 0;
    mon_pass     = 0;
    mon_fail     = 0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      seen[i] = 1'b0;
    end
    wait (monitor_on);
    forever begin
      @(negedge clk);
      lfsr = next_lfsr(lfsr);
      rt_ready_i = !lfsr[0];
      if (vxsat_o !== sat_seen) begin
        $display("MISMATCH at %0t: vxsat_o is %b, expected %b", $time, vxsat_o, sat_seen);
        mon_fail++;
      end
      if (hold_pending && (rt_valid_o !== 1'b1 || rt_tag_o !== held_tag ||
          rt_vd_o !== held_vd || rt_data_o !== held_data || rt_sat_o !== held_sat)) begin
        $display("MISMATCH at %0t: retire record changed while held", $time);
        mon_fail++;
      end
      hold_pending = rt_valid_o && !rt_ready_i;
      held_tag     = rt_tag_o;
      held_vd      = rt_vd_o;
      held_data    = rt_data_o;
      held_sat     = rt_sat_o;
      if (rt_valid_o && rt_ready_i) begin
        retired++;
        if (seen[rt_tag_o]) begin
          $display("Tag %0d retired a second time at %0t", rt_tag_o, $time);
          mon_fail++;
        end else begin
          seen[rt_tag_o] = 1'b1;
          if (rt_data_o !== exp_data[rt_tag_o] || rt_sat_o !== exp_sat[rt_tag_o] ||
              rt_vd_o !== exp_vd[rt_tag_o]) begin
            $display("MISMATCH at %0t: tag %0d %s got %0d/%h/%b, expected %0d/%h/%b",
                     $time, rt_tag_o, exp_op[rt_tag_o].name(), rt_vd_o, rt_data_o, rt_sat_o,
                     exp_vd[rt_tag_o], exp_data[rt_tag_o], exp_sat[rt_tag_o]);
            mon_fail++;
          end else begin
            $display("tag %0d %s: vd %0d data %h sat %b ok", rt_tag_o,
                     exp_op[rt_tag_o].name(), rt_vd_o, rt_data_o, rt_sat_o);
            mon_pass++;
          end
          sat_seen = sat_seen | exp_sat[rt_tag_o];
        end
      end
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin : main_sequence
    logic all_seen;
    rst_n         = 1'b0;
    inst_valid_i  = 1'b0;
    inst_op_i     = OP_LI;
    inst_vd_i     = '0;
    inst_vs1_i    = '0;
    inst_vs2_i    = '0;
    inst_imm_i    = '0;
    inst_tag_i    = '0;
    monitor_on    = 1'b0;
    ready_dropped = 1'b0;
    main_pass     = 0;
    main_fail     = 0;
    load_table();
    build_expected();
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (inst_ready_o !== 1'b1 || rt_valid_o !== 1'b0 || vxsat_o !== 1'b0) begin
      $display("MISMATCH at %0t: after reset inst_ready_o %b rt_valid_o %b vxsat_o %b",
               $time, inst_ready_o, rt_valid_o, vxsat_o);
      main_fail++;
    end else begin
      $display("reset state ok");
      main_pass++;
    end
    monitor_on = 1'b1;
    // Whole table as one burst well past the queue depth
    for (int i = 0; i < NUM_ROWS; i++) begin
      inst_valid_i = 1'b1;
      inst_op_i    = row_op[i];
      inst_vd_i    = row_vd[i];
      inst_vs1_i   = row_vs1[i];
      inst_vs2_i   = row_vs2[i];
      inst_imm_i   = row_imm[i];
      inst_tag_i   = row_tag[i];
      while (!inst_ready_o) begin
        ready_dropped = 1'b1;
        @(negedge clk);
      end
      @(negedge clk);
    end
    inst_valid_i = 1'b0;
    while (retired < NUM_ROWS) @(negedge clk);
    // Idle tail catches stray records and a dropped vxsat_o
    repeat (20) @(negedge clk);
    all_seen = 1'b1;
    for (int i = 0; i < NUM_ROWS; i++) begin
      if (!seen[i]) begin
        $display("Tag %0d never retired", i);
        all_seen = 1'b0;
      end
    end
    if (all_seen) begin
      $display("all %0d tags retired", NUM_ROWS);
      main_pass++;
    end else begin
      main_fail++;
    end
    if (ready_dropped) begin
      $display("inst_ready_o dropped under back-pressure");
      main_pass++;
    end else begin
      $display("inst_ready_o never dropped during the burst");
      main_fail++;
    end
    if (vxsat_o === 1'b1) begin
      $display("vxsat_o still set at end of run");
      main_pass++;
    end else begin
      $display("vxsat_o is not set at end of run");
      main_fail++;
    end
    $display("Checks passed: %0d, failed: %0d", main_pass + mon_pass, main_fail + mon_fail);
    if (main_fail + mon_fail == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- logic/vbe_backend.sv
`timescale 1ns/10ps

module vbe_backend import vbe_pkg::*; #(
  parameter int CQ_DEPTH   = 4,
  parameter int MUL_STAGES = 3
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             inst_valid_i,
  input  vbe_op_e          inst_op_i,
  input  logic [REG_W-1:0] inst_vd_i,
  input  logic [REG_W-1:0] inst_vs1_i,
  input  logic [REG_W-1:0] inst_vs2_i,
  input  logic [ELEN-1:0]  inst_imm_i,
  input  logic [TAG_W-1:0] inst_tag_i,
  output logic             inst_ready_o,
  output logic             rt_valid_o,
  output logic [TAG_W-1:0] rt_tag_o,
  output logic [REG_W-1:0] rt_vd_o,
  output logic [VLEN-1:0]  rt_data_o,
  output logic             rt_sat_o,
  input  logic             rt_ready_i,
  output logic             vxsat_o
);

  // Queue head
  logic             cq_valid;
  logic             cq_pop;
  vbe_op_e          cq_op;
  logic [REG_W-1:0] cq_vd;
  logic [REG_W-1:0] cq_vs1;
  logic [REG_W-1:0] cq_vs2;
  logic [ELEN-1:0]  cq_imm;
  logic [TAG_W-1:0] cq_tag;

  // Operand read and issue bus
  logic [REG_W-1:0] rd_idx_a;
  logic [REG_W-1:0] rd_idx_b;
  logic [VLEN-1:0]  rd_data_a;
  logic [VLEN-1:0]  rd_data_b;
  logic             alu_issue;
  logic             mul_issue;
  vbe_op_e          iss_op;
  logic [REG_W-1:0] iss_vd;
  logic [TAG_W-1:0] iss_tag;
  logic [VLEN-1:0]  iss_a;
  logic [VLEN-1:0]  iss_b;

  // Unit results
  logic             alu_busy;
  logic             alu_req;
  logic             alu_ack;
  logic [REG_W-1:0] alu_vd;
  logic [TAG_W-1:0] alu_tag;
  logic [VLEN-1:0]  alu_data;
  logic             alu_sat;
  logic             mul_full;
  logic             mul_req;
  logic             mul_ack;
  logic [REG_W-1:0] mul_vd;
  logic [TAG_W-1:0] mul_tag;
  logic [VLEN-1:0]  mul_data;
  logic             mul_sat;

  // Writeback, doubles as busy clear
  logic             wr_en;
  logic [REG_W-1:0] wr_idx;
  logic [VLEN-1:0]  wr_data;

  vbe_cmd_queue #(
    .CQ_DEPTH(CQ_DEPTH)
  ) u_cmd_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid_i (inst_valid_i),
    .in_op_i    (inst_op_i),
    .in_vd_i    (inst_vd_i),
    .in_vs1_i   (inst_vs1_i),
    .in_vs2_i   (inst_vs2_i),
    .in_imm_i   (inst_imm_i),
    .in_tag_i   (inst_tag_i),
    .in_ready_o (inst_ready_o),
    .out_valid_o(cq_valid),
    .out_op_o   (cq_op),
    .out_vd_o   (cq_vd),
    .out_vs1_o  (cq_vs1),
    .out_vs2_o  (cq_vs2),
    .out_imm_o  (cq_imm),
    .out_tag_o  (cq_tag),
    .pop_i      (cq_pop)
  );

  vbe_dispatch u_dispatch (
    .clk        (clk),
    .rst_n      (rst_n),
    .cq_valid_i (cq_valid),
    .cq_op_i    (cq_op),
    .cq_vd_i    (cq_vd),
    .cq_vs1_i   (cq_vs1),
    .cq_vs2_i   (cq_vs2),
    .cq_imm_i   (cq_imm),
    .cq_tag_i   (cq_tag),
    .cq_pop_o   (cq_pop),
    .rd_idx_a_o (rd_idx_a),
    .rd_idx_b_o (rd_idx_b),
    .rd_data_a_i(rd_data_a),
    .rd_data_b_i(rd_data_b),
    .alu_busy_i (alu_busy),
    .mul_full_i (mul_full),
    .alu_issue_o(alu_issue),
    .mul_issue_o(mul_issue),
    .iss_op_o   (iss_op),
    .iss_vd_o   (iss_vd),
    .iss_tag_o  (iss_tag),
    .iss_a_o    (iss_a),
    .iss_b_o    (iss_b),
    .clr_busy_i (wr_en),
    .clr_idx_i  (wr_idx)
  );

  vbe_vrf u_vrf (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_idx_a_i (rd_idx_a),
    .rd_idx_b_i (rd_idx_b),
    .rd_data_a_o(rd_data_a),
    .rd_data_b_o(rd_data_b),
    .wr_en_i    (wr_en),
    .wr_idx_i   (wr_idx),
    .wr_data_i  (wr_data)
  );

  vbe_alu u_alu (
    .clk       (clk),
    .rst_n     (rst_n),
    .issue_i   (alu_issue),
    .op_i      (iss_op),
    .vd_i      (iss_vd),
    .tag_i     (iss_tag),
    .a_i       (iss_a),
    .b_i       (iss_b),
    .busy_o    (alu_busy),
    .req_o     (alu_req),
    .ack_i     (alu_ack),
    .res_vd_o  (alu_vd),
    .res_tag_o (alu_tag),
    .res_data_o(alu_data),
    .res_sat_o (alu_sat)
  );

  vbe_mul #(
    .MUL_STAGES(MUL_STAGES)
  ) u_mul (
    .clk       (clk),
    .rst_n     (rst_n),
    .issue_i   (mul_issue),
    .vd_i      (iss_vd),
    .tag_i     (iss_tag),
    .a_i       (iss_a),
    .b_i       (iss_b),
    .full_o    (mul_full),
    .req_o     (mul_req),
    .ack_i     (mul_ack),
    .res_vd_o  (mul_vd),
    .res_tag_o (mul_tag),
    .res_data_o(mul_data),
    .res_sat_o (mul_sat)
  );

  vbe_wb_arbiter u_wb_arbiter (
    .clk       (clk),
    .rst_n     (rst_n),
    .alu_req_i (alu_req),
    .alu_vd_i  (alu_vd),
    .alu_tag_i (alu_tag),
    .alu_data_i(alu_data),
    .alu_sat_i (alu_sat),
    .alu_ack_o (alu_ack),
    .mul_req_i (mul_req),
    .mul_vd_i  (mul_vd),
    .mul_tag_i (mul_tag),
    .mul_data_i(mul_data),
    .mul_sat_i (mul_sat),
    .mul_ack_o (mul_ack),
    .wr_en_o   (wr_en),
    .wr_idx_o  (wr_idx),
    .wr_data_o (wr_data),
    .rt_valid_o(rt_valid_o),
    .rt_tag_o  (rt_tag_o),
    .rt_vd_o   (rt_vd_o),
    .rt_data_o (rt_data_o),
    .rt_sat_o  (rt_sat_o),
    .rt_ready_i(rt_ready_i),
    .vxsat_o   (vxsat_o)
  );

endmodule

//--- logic/vbe_wb_arbiter.sv
`timescale 1ns/10ps

module vbe_wb_arbiter import vbe_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             alu_req_i,
  input  logic [REG_W-1:0] alu_vd_i,
  input  logic [TAG_W-1:0] alu_tag_i,
  input  logic [VLEN-1:0]  alu_data_i,
  input  logic             alu_sat_i,
  output logic             alu_ack_o,
  input  logic             mul_req_i,
  input  logic [REG_W-1:0] mul_vd_i,
  input  logic [TAG_W-1:0] mul_tag_i,
  input  logic [VLEN-1:0]  mul_data_i,
  input  logic             mul_sat_i,
  output logic             mul_ack_o,
  output logic             wr_en_o,
  output logic [REG_W-1:0] wr_idx_o,
  output logic [VLEN-1:0]  wr_data_o,
  output logic             rt_valid_o,
  output logic [TAG_W-1:0] rt_tag_o,
  output logic [REG_W-1:0] rt_vd_o,
  output logic [VLEN-1:0]  rt_data_o,
  output logic             rt_sat_o,
  input  logic             rt_ready_i,
  output logic             vxsat_o
);

  typedef enum logic [1:0] {
    IDLE,
    PRESENT,
    ACK_HI
  } arb_state_e;

  arb_state_e state;
  logic       last_mul;
  logic       pick_mul;
  logic       grant;
  logic       owner_req;

  // Last winner loses a tie
  assign pick_mul  = mul_req_i & (!alu_req_i | !last_mul);
  assign grant     = (state == IDLE) & (alu_req_i | mul_req_i);
  assign owner_req = last_mul ? mul_req_i : alu_req_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      last_mul <= 1'b0;
      vxsat_o  <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (grant) begin
            state    <= PRESENT;
            last_mul <= pick_mul;
          end
        end
        PRESENT: if (rt_ready_i) state <= ACK_HI;
        ACK_HI:  if (!owner_req) state <= IDLE;
        default: state <= IDLE;
      endcase
      if (wr_en_o && rt_sat_o) vxsat_o <= 1'b1;
    end
  end

  // Retire record, loaded only at grant
  always_ff @(posedge clk) begin
    if (grant) begin
      rt_tag_o  <= pick_mul ? mul_tag_i : alu_tag_i;
      rt_vd_o   <= pick_mul ? mul_vd_i : alu_vd_i;
      rt_data_o <= pick_mul ? mul_data_i : alu_data_i;
      rt_sat_o  <= pick_mul ? mul_sat_i : alu_sat_i;
    end
  end

  assign rt_valid_o = (state == PRESENT);
  assign wr_en_o    = (state == PRESENT) & rt_ready_i;
  assign wr_idx_o   = rt_vd_o;
  assign wr_data_o  = rt_data_o;
  assign alu_ack_o  = (state == ACK_HI) & !last_mul;
  assign mul_ack_o  = (state == ACK_HI) & last_mul;

endmodule

//--- logic/vbe_mul.sv
`timescale 1ns/10ps

module vbe_mul import vbe_pkg::*; #(
  parameter int MUL_STAGES = 3
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             issue_i,
  input  logic [REG_W-1:0] vd_i,
  input  logic [TAG_W-1:0] tag_i,
  input  logic [VLEN-1:0]  a_i,
  input  logic [VLEN-1:0]  b_i,
  output logic             full_o,
  output logic             req_o,
  input  logic             ack_i,
  output logic [REG_W-1:0] res_vd_o,
  output logic [TAG_W-1:0] res_tag_o,
  output logic [VLEN-1:0]  res_data_o,
  output logic             res_sat_o
);

  localparam int LAST = MUL_STAGES - 1;

  vbe_hs_e          state;
  logic             stg_valid [MUL_STAGES];
  logic [REG_W-1:0] stg_vd    [MUL_STAGES];
  logic [TAG_W-1:0] stg_tag   [MUL_STAGES];
  logic [VLEN-1:0]  stg_data  [MUL_STAGES];

  // Stage inputs and per-stage load enables
  logic             src_valid [MUL_STAGES];
  logic [REG_W-1:0] src_vd    [MUL_STAGES];
  logic [TAG_W-1:0] src_tag   [MUL_STAGES];
  logic [VLEN-1:0]  src_data  [MUL_STAGES];
  logic             take      [MUL_STAGES];
  logic             load_last;

  always_comb begin
    src_valid[0] = issue_i;
    src_vd[0]    = vd_i;
    src_tag[0]   = tag_i;
    src_data[0]  = lane_mul(a_i, b_i);
    for (int i = 1; i < MUL_STAGES; i++) begin
      src_valid[i] = stg_valid[i-1];
      src_vd[i]    = stg_vd[i-1];
      src_tag[i]   = stg_tag[i-1];
      src_data[i]  = stg_data[i-1];
    end
    // Output stage frees up once ack has been seen low again
    take[LAST] = !stg_valid[LAST] && !(state == HS_WAIT_ACK_LOW && ack_i);
    for (int i = LAST - 1; i >= 0; i--) begin
      take[i] = !stg_valid[i] || take[i+1];
    end
  end

  assign load_last = take[LAST] & src_valid[LAST];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < MUL_STAGES; i++) begin
        stg_valid[i] <= 1'b0;
      end
    end else begin
      for (int i = 0; i < MUL_STAGES; i++) begin
        if (take[i]) begin
          stg_valid[i] <= src_valid[i];
        end else if (i == LAST && state == HS_REQ && ack_i) begin
          stg_valid[i] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < MUL_STAGES; i++) begin
      if (take[i]) begin
        stg_vd[i]   <= src_vd[i];
        stg_tag[i]  <= src_tag[i];
        stg_data[i] <= src_data[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= HS_IDLE;
    end else begin
      case (state)
        HS_IDLE:         if (load_last) state <= HS_REQ;
        HS_REQ:          if (ack_i) state <= HS_WAIT_ACK_LOW;
        HS_WAIT_ACK_LOW: if (!ack_i) state <= load_last ? HS_REQ : HS_IDLE;
        default:         state <= HS_IDLE;
      endcase
    end
  end

  assign full_o     = !take[0];
  assign req_o      = (state == HS_REQ);
  assign res_vd_o   = stg_vd[LAST];
  assign res_tag_o  = stg_tag[LAST];
  assign res_data_o = stg_data[LAST];
  // Wrapping product, never saturates
  assign res_sat_o  = 1'b0;

endmodule

//--- logic/vbe_alu.sv
`timescale 1ns/10ps

module vbe_alu import vbe_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             issue_i,
  input  vbe_op_e          op_i,
  input  logic [REG_W-1:0] vd_i,
  input  logic [TAG_W-1:0] tag_i,
  input  logic [VLEN-1:0]  a_i,
  input  logic [VLEN-1:0]  b_i,
  output logic             busy_o,
  output logic             req_o,
  input  logic             ack_i,
  output logic [REG_W-1:0] res_vd_o,
  output logic [TAG_W-1:0] res_tag_o,
  output logic [VLEN-1:0]  res_data_o,
  output logic             res_sat_o
);

  vbe_hs_e         state;
  logic [VLEN-1:0] alu_res;
  logic            alu_sat;

  always_comb begin
    alu_res = '0;
    alu_sat = 1'b0;
    case (op_i)
      OP_LI:    alu_res = a_i;
      OP_ADD:   alu_res = lane_addsub(a_i, b_i, 1'b0);
      OP_SUB:   alu_res = lane_addsub(a_i, b_i, 1'b1);
      OP_SADDU: {alu_sat, alu_res} = lane_saddu(a_i, b_i);
      OP_AND:   alu_res = a_i & b_i;
      OP_XOR:   alu_res = a_i ^ b_i;
      default:  alu_res = '0;
    endcase
  end

  // Result hold register, stable for the whole handshake
  always_ff @(posedge clk) begin
    if (issue_i) begin
      res_vd_o   <= vd_i;
      res_tag_o  <= tag_i;
      res_data_o <= alu_res;
      res_sat_o  <= alu_sat;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= HS_IDLE;
    end else begin
      case (state)
        HS_IDLE:         if (issue_i) state <= HS_REQ;
        HS_REQ:          if (ack_i) state <= HS_WAIT_ACK_LOW;
        HS_WAIT_ACK_LOW: if (!ack_i) state <= HS_IDLE;
        default:         state <= HS_IDLE;
      endcase
    end
  end

  // Dispatch only issues here in IDLE
  assign busy_o = (state != HS_IDLE);
  assign req_o  = (state == HS_REQ);

endmodule

//--- logic/vbe_vrf.sv
`timescale 1ns/10ps

module vbe_vrf import vbe_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [REG_W-1:0] rd_idx_a_i,
  input  logic [REG_W-1:0] rd_idx_b_i,
  output logic [VLEN-1:0]  rd_data_a_o,
  output logic [VLEN-1:0]  rd_data_b_o,
  input  logic             wr_en_i,
  input  logic [REG_W-1:0] wr_idx_i,
  input  logic [VLEN-1:0]  wr_data_i
);

  logic [VLEN-1:0] regs [NUM_VREG];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_VREG; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i) begin
      regs[wr_idx_i] <= wr_data_i;
    end
  end

  // Reads see the old value during a write cycle
  assign rd_data_a_o = regs[rd_idx_a_i];
  assign rd_data_b_o = regs[rd_idx_b_i];

endmodule

//--- logic/vbe_dispatch.sv
`timescale 1ns/10ps

module vbe_dispatch import vbe_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             cq_valid_i,
  input  vbe_op_e          cq_op_i,
  input  logic [REG_W-1:0] cq_vd_i,
  input  logic [REG_W-1:0] cq_vs1_i,
  input  logic [REG_W-1:0] cq_vs2_i,
  input  logic [ELEN-1:0]  cq_imm_i,
  input  logic [TAG_W-1:0] cq_tag_i,
  output logic             cq_pop_o,
  output logic [REG_W-1:0] rd_idx_a_o,
  output logic [REG_W-1:0] rd_idx_b_o,
  input  logic [VLEN-1:0]  rd_data_a_i,
  input  logic [VLEN-1:0]  rd_data_b_i,
  input  logic             alu_busy_i,
  input  logic             mul_full_i,
  output logic             alu_issue_o,
  output logic             mul_issue_o,
  output vbe_op_e          iss_op_o,
  output logic [REG_W-1:0] iss_vd_o,
  output logic [TAG_W-1:0] iss_tag_o,
  output logic [VLEN-1:0]  iss_a_o,
  output logic [VLEN-1:0]  iss_b_o,
  input  logic             clr_busy_i,
  input  logic [REG_W-1:0] clr_idx_i
);

  logic [NUM_VREG-1:0] busy;
  logic                to_mul;
  logic                uses_src;
  logic                hazard;
  logic                unit_ok;
  logic                issue;

  // Unit select and hazard check on the queue head
  assign to_mul   = (cq_op_i == OP_MUL);
  assign uses_src = (cq_op_i != OP_LI);
  assign hazard   = busy[cq_vd_i] |
                    (uses_src & (busy[cq_vs1_i] | busy[cq_vs2_i]));
  assign unit_ok  = to_mul ? !mul_full_i : !alu_busy_i;
  assign issue    = cq_valid_i & !hazard & unit_ok;

  assign cq_pop_o    = issue;
  assign alu_issue_o = issue & !to_mul;
  assign mul_issue_o = issue & to_mul;

  // Operand read straight from the head
  assign rd_idx_a_o = cq_vs1_i;
  assign rd_idx_b_o = cq_vs2_i;

  assign iss_op_o  = cq_op_i;
  assign iss_vd_o  = cq_vd_i;
  assign iss_tag_o = cq_tag_i;
  assign iss_a_o   = uses_src ? rd_data_a_i : lane_broadcast(cq_imm_i);
  assign iss_b_o   = rd_data_b_i;

  // Set and clear never hit the same register in one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= '0;
    end else begin
      if (clr_busy_i) busy[clr_idx_i] <= 1'b0;
      if (issue) busy[cq_vd_i] <= 1'b1;
    end
  end

endmodule

//--- logic/vbe_cmd_queue.sv
`timescale 1ns/10ps

module vbe_cmd_queue import vbe_pkg::*; #(
  parameter int CQ_DEPTH = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid_i,
  input  vbe_op_e          in_op_i,
  input  logic [REG_W-1:0] in_vd_i,
  input  logic [REG_W-1:0] in_vs1_i,
  input  logic [REG_W-1:0] in_vs2_i,
  input  logic [ELEN-1:0]  in_imm_i,
  input  logic [TAG_W-1:0] in_tag_i,
  output logic             in_ready_o,
  output logic             out_valid_o,
  output vbe_op_e          out_op_o,
  output logic [REG_W-1:0] out_vd_o,
  output logic [REG_W-1:0] out_vs1_o,
  output logic [REG_W-1:0] out_vs2_o,
  output logic [ELEN-1:0]  out_imm_o,
  output logic [TAG_W-1:0] out_tag_o,
  input  logic             pop_i
);

  localparam int PTR_W = $clog2(CQ_DEPTH);
  localparam int CNT_W = $clog2(CQ_DEPTH + 1);

  vbe_op_e          op_q  [CQ_DEPTH];
  logic [REG_W-1:0] vd_q  [CQ_DEPTH];
  logic [REG_W-1:0] vs1_q [CQ_DEPTH];
  logic [REG_W-1:0] vs2_q [CQ_DEPTH];
  logic [ELEN-1:0]  imm_q [CQ_DEPTH];
  logic [TAG_W-1:0] tag_q [CQ_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // Wrap explicitly so any depth works
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(CQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign in_ready_o  = (count != CNT_W'(CQ_DEPTH));
  assign out_valid_o = (count != '0);
  assign push        = in_valid_i & in_ready_o;
  assign pop         = pop_i & out_valid_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      op_q[wr_ptr]  <= in_op_i;
      vd_q[wr_ptr]  <= in_vd_i;
      vs1_q[wr_ptr] <= in_vs1_i;
      vs2_q[wr_ptr] <= in_vs2_i;
      imm_q[wr_ptr] <= in_imm_i;
      tag_q[wr_ptr] <= in_tag_i;
    end
  end

  assign out_op_o  = op_q[rd_ptr];
  assign out_vd_o  = vd_q[rd_ptr];
  assign out_vs1_o = vs1_q[rd_ptr];
  assign out_vs2_o = vs2_q[rd_ptr];
  assign out_imm_o = imm_q[rd_ptr];
  assign out_tag_o = tag_q[rd_ptr];

endmodule

//--- logic/vbe_pkg.sv
package vbe_pkg;

  localparam int VLEN      = 32;
  localparam int ELEN      = 8;
  localparam int NUM_LANES = VLEN / ELEN;
  localparam int NUM_VREG  = 8;
  localparam int REG_W     = 3;
  localparam int TAG_W     = 4;

  typedef enum logic [2:0] {
    OP_LI,
    OP_ADD,
    OP_SUB,
    OP_SADDU,
    OP_AND,
    OP_XOR,
    OP_MUL
  } vbe_op_e;

  // Unit side of the four-phase result handshake
  typedef enum logic [1:0] {
    HS_IDLE,
    HS_REQ,
    HS_WAIT_ACK_LOW
  } vbe_hs_e;

  function automatic logic [VLEN-1:0] lane_broadcast(input logic [ELEN-1:0] val);
    return {NUM_LANES{val}};
  endfunction

  // Wrapping add or subtract per lane
  function automatic logic [VLEN-1:0] lane_addsub(input logic [VLEN-1:0] a,
                                                  input logic [VLEN-1:0] b,
                                                  input logic sub);
    logic [VLEN-1:0] res;
    for (int i = 0; i < NUM_LANES; i++) begin
      res[i*ELEN +: ELEN] = sub ? a[i*ELEN +: ELEN] - b[i*ELEN +: ELEN]
                                : a[i*ELEN +: ELEN] + b[i*ELEN +: ELEN];
    end
    return res;
  endfunction

  // Top bit is set when any lane clamped
  function automatic logic [VLEN:0] lane_saddu(input logic [VLEN-1:0] a,
                                               input logic [VLEN-1:0] b);
    logic [ELEN:0]   sum;
    logic [VLEN-1:0] res;
    logic            sat;
    sat = 1'b0;
    for (int i = 0; i < NUM_LANES; i++) begin
      sum = {1'b0, a[i*ELEN +: ELEN]} + {1'b0, b[i*ELEN +: ELEN]};
      if (sum[ELEN]) begin
        res[i*ELEN +: ELEN] = '1;
        sat = 1'b1;
      end else begin
        res[i*ELEN +: ELEN] = sum[ELEN-1:0];
      end
    end
    return {sat, res};
  endfunction

  // Low half of each lane product
  function automatic logic [VLEN-1:0] lane_mul(input logic [VLEN-1:0] a,
                                               input logic [VLEN-1:0] b);
    logic [VLEN-1:0] res;
    for (int i = 0; i < NUM_LANES; i++) begin
      res[i*ELEN +: ELEN] = a[i*ELEN +: ELEN] * b[i*ELEN +: ELEN];
    end
    return res;
  endfunction

endpackage
